// ==== logic/serial_link_pkg.sv ====
package serial_link_pkg;

  //////////////////////////////////////////////////
  // Flit format
  //////////////////////////////////////////////////

  // Data word carried by one flit
  parameter int FlitWidth = 32;

  // Header bit on top of the data word
  parameter int PayloadWidth = FlitWidth + 1;

  typedef logic [FlitWidth-1:0] flit_data_t;

  // Unit that gets split into beats
  typedef logic [PayloadWidth-1:0] payload_t;

  //////////////////////////////////////////////////
  // Default link settings
  //////////////////////////////////////////////////

  // Data lanes per direction
  parameter int DefaultNumLanes = 4;

  // clk_i cycles per forwarded clock period, multiple of 4
  parameter int DefaultClkDiv = 8;

endpackage

// ==== logic/serial_link_beat_if.sv ====
`timescale 1ns/100ps

interface serial_link_beat_if #(
  parameter int BeatWidth = 2 * serial_link_pkg::DefaultNumLanes
);

  typedef logic [BeatWidth-1:0] beat_t;

  // Transmit beat handshake
  beat_t tx_beat;
  logic  tx_valid;
  logic  tx_ready;

  // Received beat strobe
  beat_t rx_beat;
  logic  rx_valid;

  modport link (
    output tx_beat,
    output tx_valid,
    input  tx_ready,
    input  rx_beat,
    input  rx_valid
  );

  modport phy (
    input  tx_beat,
    input  tx_valid,
    output tx_ready,
    output rx_beat,
    output rx_valid
  );

endinterface

// ==== logic/serial_link_data_link.sv ====
`timescale 1ns/100ps

module serial_link_data_link #(
  parameter int NumLanes = serial_link_pkg::DefaultNumLanes
) (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        flit_valid_i,
  output logic                        flit_ready_o,
  input  logic                        flit_hdr_i,
  input  serial_link_pkg::flit_data_t flit_data_i,
  output logic                        flit_valid_o,
  output logic                        flit_hdr_o,
  output serial_link_pkg::flit_data_t flit_data_o,
  serial_link_beat_if.link            beat
);

  localparam int BeatWidth   = 2 * NumLanes;
  localparam int NumSplits   = (serial_link_pkg::PayloadWidth + BeatWidth - 1) / BeatWidth;
  localparam int PaddedWidth = NumSplits * BeatWidth;
  localparam int CntWidth    = $clog2(NumSplits + 1);

  typedef logic [PaddedWidth-1:0] padded_t;
  typedef logic [CntWidth-1:0]    split_cnt_t;

  typedef enum logic {
    LinkTxIdle,
    LinkTxSending
  } link_tx_state_e;

  //////////////////////////////////////////////////
  // Transmit split
  //////////////////////////////////////////////////

  link_tx_state_e            tx_state_q;
  split_cnt_t                tx_cnt_q;
  padded_t                   tx_shift_q;
  serial_link_pkg::payload_t tx_payload;
  logic                      flit_accept;
  logic                      beat_accept;

  assign tx_payload   = {flit_hdr_i, flit_data_i};
  assign flit_ready_o = (tx_state_q == LinkTxIdle);
  assign flit_accept  = flit_valid_i & flit_ready_o;
  assign beat_accept  = beat.tx_valid & beat.tx_ready;

  // Lowest bits leave first
  assign beat.tx_valid = (tx_state_q == LinkTxSending);
  assign beat.tx_beat  = tx_shift_q[BeatWidth-1:0];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      tx_state_q <= LinkTxIdle;
      tx_cnt_q   <= '0;
    end else begin
      case (tx_state_q)
        LinkTxIdle: begin
          if (flit_accept) begin
            tx_state_q <= LinkTxSending;
            tx_cnt_q   <= '0;
          end
        end
        LinkTxSending: begin
          if (beat_accept) begin
            // Last split handed to the phy
            if (tx_cnt_q == split_cnt_t'(NumSplits - 1)) begin
              tx_state_q <= LinkTxIdle;
              tx_cnt_q   <= '0;
            end else begin
              tx_cnt_q <= tx_cnt_q + 1'b1;
            end
          end
        end
        default: begin
          tx_state_q <= LinkTxIdle;
        end
      endcase
    end
  end

  // Zero padded payload, shifted down one beat per handshake
  always_ff @(posedge clk_i) begin
    if (flit_accept) begin
      tx_shift_q <= padded_t'(tx_payload);
    end else if (beat_accept) begin
      tx_shift_q <= tx_shift_q >> BeatWidth;
    end
  end

  //////////////////////////////////////////////////
  // Receive reassembly
  //////////////////////////////////////////////////

  padded_t                   rx_shift_q;
  split_cnt_t                rx_cnt_q;
  logic                      flit_valid_q;
  serial_link_pkg::payload_t rx_payload;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rx_cnt_q     <= '0;
      flit_valid_q <= 1'b0;
    end else begin
      flit_valid_q <= 1'b0;
      if (beat.rx_valid) begin
        if (rx_cnt_q == split_cnt_t'(NumSplits - 1)) begin
          rx_cnt_q     <= '0;
          flit_valid_q <= 1'b1;
        end else begin
          rx_cnt_q <= rx_cnt_q + 1'b1;
        end
      end
    end
  end

  // New beats enter at the top, so the first one ends at the bottom
  always_ff @(posedge clk_i) begin
    if (beat.rx_valid) begin
      rx_shift_q <= padded_t'({beat.rx_beat, rx_shift_q} >> BeatWidth);
    end
  end

  assign rx_payload   = rx_shift_q[serial_link_pkg::PayloadWidth-1:0];
  assign flit_valid_o = flit_valid_q;
  assign flit_hdr_o   = rx_payload[serial_link_pkg::PayloadWidth-1];
  assign flit_data_o  = rx_payload[serial_link_pkg::FlitWidth-1:0];

  //////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////

  tx_cnt_bound_a: assert property (@(posedge clk_i) disable iff (rst_i)
    (tx_state_q == LinkTxSending) |-> (tx_cnt_q < split_cnt_t'(NumSplits)))
    else $error("transmit beat count beyond split count");

  // Phy beat spacing keeps the output register free during the strobe
  rx_gap_a: assert property (@(posedge clk_i) disable iff (rst_i)
    flit_valid_q |-> !beat.rx_valid)
    else $error("beat received during flit output strobe");

endmodule

// ==== logic/serial_link_physical.sv ====
`timescale 1ns/100ps

module serial_link_physical #(
  parameter int NumLanes = serial_link_pkg::DefaultNumLanes,
  parameter int ClkDiv   = serial_link_pkg::DefaultClkDiv
) (
  input  logic                clk_i,
  input  logic                rst_i,
  serial_link_beat_if.phy     beat,
  input  logic                ddr_rcv_clk_i,
  output logic                ddr_rcv_clk_o,
  input  logic [NumLanes-1:0] ddr_i,
  output logic [NumLanes-1:0] ddr_o
);

  localparam int HalfPeriod    = ClkDiv / 2;
  localparam int QuarterPeriod = ClkDiv / 4;
  localparam int CntWidth      = (HalfPeriod > 1) ? $clog2(HalfPeriod) : 1;

  typedef logic [NumLanes-1:0]   lanes_t;
  typedef logic [2*NumLanes-1:0] beat_t;
  typedef logic [CntWidth-1:0]   half_cnt_t;

  typedef enum logic [1:0] {
    PhyTxIdle,
    PhyTxLow,
    PhyTxHigh
  } phy_tx_state_e;

  //////////////////////////////////////////////////
  // DDR transmit
  //////////////////////////////////////////////////

  phy_tx_state_e tx_state_q;
  half_cnt_t     half_cnt_q;
  beat_t         tx_beat_q;
  lanes_t        ddr_d;
  lanes_t        ddr_q;
  logic          clk_d;
  logic          clk_q;
  logic          beat_accept;

  assign beat.tx_ready = (tx_state_q == PhyTxIdle);
  assign beat_accept   = beat.tx_valid & beat.tx_ready;

  // Next lane and clock levels
  // The clock edge sits a quarter period after each data change
  always_comb begin
    ddr_d = '0;
    clk_d = 1'b0;
    case (tx_state_q)
      PhyTxIdle: begin
        if (beat_accept) begin
          ddr_d = beat.tx_beat[NumLanes-1:0];
        end
      end
      PhyTxLow: begin
        ddr_d = tx_beat_q[NumLanes-1:0];
        clk_d = (half_cnt_q >= half_cnt_t'(QuarterPeriod));
      end
      PhyTxHigh: begin
        ddr_d = tx_beat_q[2*NumLanes-1:NumLanes];
        clk_d = (half_cnt_q < half_cnt_t'(QuarterPeriod));
      end
      default: begin
        ddr_d = '0;
      end
    endcase
  end

  // Acceptance cycle counts as position 0 of the low half
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      tx_state_q <= PhyTxIdle;
      half_cnt_q <= '0;
      ddr_q      <= '0;
      clk_q      <= 1'b0;
    end else begin
      ddr_q <= ddr_d;
      clk_q <= clk_d;
      case (tx_state_q)
        PhyTxIdle: begin
          if (beat_accept) begin
            tx_state_q <= PhyTxLow;
            half_cnt_q <= half_cnt_t'(1);
          end
        end
        PhyTxLow: begin
          if (half_cnt_q == half_cnt_t'(HalfPeriod - 1)) begin
            tx_state_q <= PhyTxHigh;
            half_cnt_q <= '0;
          end else begin
            half_cnt_q <= half_cnt_q + 1'b1;
          end
        end
        PhyTxHigh: begin
          if (half_cnt_q == half_cnt_t'(HalfPeriod - 1)) begin
            tx_state_q <= PhyTxIdle;
            half_cnt_q <= '0;
          end else begin
            half_cnt_q <= half_cnt_q + 1'b1;
          end
        end
        default: begin
          tx_state_q <= PhyTxIdle;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (beat_accept) begin
      tx_beat_q <= beat.tx_beat;
    end
  end

  assign ddr_o         = ddr_q;
  assign ddr_rcv_clk_o = clk_q;

  //////////////////////////////////////////////////
  // DDR receive
  //////////////////////////////////////////////////

  logic   rcv_clk_q;
  logic   rcv_clk_prev_q;
  logic   rcv_rise;
  logic   rcv_fall;
  logic   rx_valid_q;
  lanes_t ddr_in_q;
  lanes_t rx_low_q;
  beat_t  rx_beat_q;

  assign rcv_rise = rcv_clk_q & ~rcv_clk_prev_q;
  assign rcv_fall = ~rcv_clk_q & rcv_clk_prev_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rcv_clk_q      <= 1'b0;
      rcv_clk_prev_q <= 1'b0;
      rx_valid_q     <= 1'b0;
    end else begin
      rcv_clk_q      <= ddr_rcv_clk_i;
      rcv_clk_prev_q <= rcv_clk_q;
      rx_valid_q     <= rcv_fall;
    end
  end

  // Low half on the rising edge, high half on the falling edge
  always_ff @(posedge clk_i) begin
    ddr_in_q <= ddr_i;
    if (rcv_rise) begin
      rx_low_q <= ddr_in_q;
    end
    if (rcv_fall) begin
      rx_beat_q <= {ddr_in_q, rx_low_q};
    end
  end

  assign beat.rx_beat  = rx_beat_q;
  assign beat.rx_valid = rx_valid_q;

  //////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////

  tx_accept_idle_a: assert property (@(posedge clk_i) disable iff (rst_i)
    beat_accept |-> (tx_state_q == PhyTxIdle) ##1 (!beat.tx_ready) [* ClkDiv - 1]
      ##1 beat.tx_ready)
    else $error("beat taken outside idle or wrong beat length");

  tx_idle_clk_low_a: assert property (@(posedge clk_i) disable iff (rst_i)
    (tx_state_q == PhyTxIdle) |-> !ddr_rcv_clk_o)
    else $error("forwarded clock high while idle");

endmodule

// ==== logic/serial_link.sv ====
`timescale 1ns/100ps

module serial_link #(
  parameter int NumLanes = serial_link_pkg::DefaultNumLanes,
  parameter int ClkDiv   = serial_link_pkg::DefaultClkDiv
) (
  input  logic                        clk_i,
  input  logic                        rst_i,
  // Flit input
  input  logic                        flit_valid_i,
  output logic                        flit_ready_o,
  input  logic                        flit_hdr_i,
  input  serial_link_pkg::flit_data_t flit_data_i,
  // Flit output strobe
  output logic                        flit_valid_o,
  output logic                        flit_hdr_o,
  output serial_link_pkg::flit_data_t flit_data_o,
  // Off-chip lines
  input  logic                        ddr_rcv_clk_i,
  output logic                        ddr_rcv_clk_o,
  input  logic [NumLanes-1:0]         ddr_i,
  output logic [NumLanes-1:0]         ddr_o
);

  // Beats between link and phy
  serial_link_beat_if #(.BeatWidth(2 * NumLanes)) beat0 ();

  serial_link_data_link #(
    .NumLanes     ( NumLanes     )
  ) data_link0 (
    .clk_i        ( clk_i        ),
    .rst_i        ( rst_i        ),
    .flit_valid_i ( flit_valid_i ),
    .flit_ready_o ( flit_ready_o ),
    .flit_hdr_i   ( flit_hdr_i   ),
    .flit_data_i  ( flit_data_i  ),
    .flit_valid_o ( flit_valid_o ),
    .flit_hdr_o   ( flit_hdr_o   ),
    .flit_data_o  ( flit_data_o  ),
    .beat         ( beat0.link   )
  );

  serial_link_physical #(
    .NumLanes      ( NumLanes      ),
    .ClkDiv        ( ClkDiv        )
  ) phy0 (
    .clk_i         ( clk_i         ),
    .rst_i         ( rst_i         ),
    .beat          ( beat0.phy     ),
    .ddr_rcv_clk_i ( ddr_rcv_clk_i ),
    .ddr_rcv_clk_o ( ddr_rcv_clk_o ),
    .ddr_i         ( ddr_i         ),
    .ddr_o         ( ddr_o         )
  );

endmodule

// ==== test/tb_clk_gen.sv ====
`timescale 1ns/100ps

module tb_clk_gen #(
  parameter int PeriodNs    = 20,
  parameter int ResetCycles = 2
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  // Reset drops on a rising edge like every other input
  initial begin
    rst_o = 1'b1;
    repeat (ResetCycles) @(posedge clk_o);
    rst_o <= 1'b0;
  end

endmodule

// ==== test/tb_checker.sv ====
`timescale 1ns/100ps

module tb_checker #(
  parameter int NumLanes  = 4,
  parameter int ClkDiv    = 8,
  parameter int NumSplits = 5
) (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        flit_valid_i,
  input  logic                        flit_ready_i,
  input  logic                        flit_hdr_i,
  input  serial_link_pkg::flit_data_t flit_data_i,
  input  logic                        out_valid_i,
  input  logic                        out_hdr_i,
  input  serial_link_pkg::flit_data_t out_data_i,
  input  logic                        line_clk_i,
  input  logic [NumLanes-1:0]         line_data_i,
  input  int                          test_num_i,
  input  logic                        test_end_i,
  input  logic                        run_done_i,
  output int                          received_o,
  output int                          err_cnt_o
);

  localparam int Pw          = serial_link_pkg::PayloadWidth;
  localparam int ReadyLowMin = (NumSplits - 1) * ClkDiv + 1;
  localparam int ReadyLowMax = NumSplits * ClkDiv;

  // Accepted flits still on their way with the header on top
  logic [Pw-1:0] model_q[$];
  logic [Pw-1:0] expected;

  int   errors = 0;
  int   start_errors = 0;
  int   tests_passed = 0;
  int   tests_failed = 0;
  int   accepted = 0;
  int   received = 0;
  int   edges = 0;
  int   bp_low = 0;
  int   idle_cnt = 0;
  logic bp_active = 1'b0;
  logic first_cycle = 1'b1;
  logic prev_clk = 1'b0;
  logic accept;

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("ERR %s expected %h actual %h at %0t", name, exp, act, $time);
    errors++;
  endtask

  task automatic report_failure(input string msg);
    $display("Error: %s at %0t", msg, $time);
    errors++;
  endtask

  function automatic string test_name(input int num);
    case (num)
      1: return "reset state";
      2: return "single flit";
      3: return "random stream";
      4: return "transmit back-pressure";
      5: return "physical line";
      default: return "unknown";
    endcase
  endfunction

  always @(posedge clk_i) begin
    if (rst_i) begin
      first_cycle = 1'b1;
      prev_clk    = 1'b0;
      bp_active   = 1'b0;
      idle_cnt    = 0;
    end else begin
      if (first_cycle) begin
        if (flit_ready_i !== 1'b1) begin
          report_mismatch("flit_ready_o", 32'h1, flit_ready_i);
        end
        if (out_valid_i !== 1'b0) begin
          report_mismatch("flit_valid_o", 32'h0, out_valid_i);
        end
        if (line_data_i !== '0) begin
          report_mismatch("ddr_o", 32'h0, line_data_i);
        end
        if (line_clk_i !== 1'b0) begin
          report_mismatch("ddr_rcv_clk_o", 32'h0, line_clk_i);
        end
        first_cycle = 1'b0;
      end

      ////////////////////////////////////////////////
      // Received flits against the model queue
      ////////////////////////////////////////////////
      if (out_valid_i === 1'b1) begin
        if (model_q.size() == 0) begin
          report_failure("flit output with no flit outstanding");
        end else begin
          expected = model_q.pop_front();
          if (out_hdr_i !== expected[Pw-1]) begin
            report_mismatch("flit_hdr_o", expected[Pw-1], out_hdr_i);
          end
          if (out_data_i !== expected[Pw-2:0]) begin
            report_mismatch("flit_data_o", expected[Pw-2:0], out_data_i);
          end
        end
        received++;
      end

      // Forwarded clock only changes on clk_i edges
      if (line_clk_i !== prev_clk) begin
        edges++;
      end
      prev_clk = line_clk_i;

      // Ready low time grows when the first beat waits for the previous last beat
      if (bp_active) begin
        if (!flit_ready_i) begin
          bp_low++;
        end else begin
          if (bp_low < ReadyLowMin || bp_low > ReadyLowMax) begin
            report_failure($sformatf("flit_ready_o low for %0d cycles, expected %0d to %0d",
                                     bp_low, ReadyLowMin, ReadyLowMax));
          end
          bp_active = 1'b0;
        end
      end

      // Lines quiet once nothing was accepted for a whole forwarded period
      if (idle_cnt >= ClkDiv) begin
        if (line_data_i !== '0) begin
          report_mismatch("ddr_o", 32'h0, line_data_i);
        end
        if (line_clk_i !== 1'b0) begin
          report_mismatch("ddr_rcv_clk_o", 32'h0, line_clk_i);
        end
      end
      accept = flit_valid_i & flit_ready_i;
      if (flit_ready_i && !accept) begin
        idle_cnt++;
      end else begin
        idle_cnt = 0;
      end

      if (accept) begin
        // Older flits are done except maybe the edges of their last beat
        if (edges < 2 * NumSplits * accepted - 2 || edges > 2 * NumSplits * accepted) begin
          report_failure($sformatf("%0d forwarded clock edges before flit %0d, expected %0d",
                                   edges, accepted, 2 * NumSplits * accepted));
        end
        model_q.push_back({flit_hdr_i, flit_data_i});
        accepted++;
        bp_active = 1'b1;
        bp_low    = 0;
      end

      ////////////////////////////////////////////////
      // End of test and end of run
      ////////////////////////////////////////////////
      if (test_end_i) begin
        if (model_q.size() != 0) begin
          report_failure($sformatf("%0d accepted flits never came out", model_q.size()));
        end
        if (edges != 2 * NumSplits * accepted) begin
          report_failure($sformatf("%0d forwarded clock edges in total, expected %0d",
                                   edges, 2 * NumSplits * accepted));
        end
        if (errors == start_errors) begin
          tests_passed++;
          $display("Test %0d %s: PASS", test_num_i, test_name(test_num_i));
        end else begin
          tests_failed++;
          $display("Test %0d %s: FAIL with %0d errors", test_num_i, test_name(test_num_i),
                   errors - start_errors);
        end
        start_errors = errors;
      end
      if (run_done_i) begin
        $display("Summary: %0d tests, %0d passed, %0d failed, %0d sent, %0d received, %0d errors",
                 tests_passed + tests_failed, tests_passed, tests_failed, accepted, received,
                 errors);
      end
    end
    received_o <= received;
    err_cnt_o  <= errors;
  end

endmodule

// ==== test/tb_serial_link.sv ====
`timescale 1ns/100ps

module tb_serial_link;

  localparam int NumLanes      = serial_link_pkg::DefaultNumLanes;
  localparam int ClkDiv        = serial_link_pkg::DefaultClkDiv;
  localparam int BeatWidth     = 2 * NumLanes;
  localparam int NumSplits     = (serial_link_pkg::PayloadWidth + BeatWidth - 1) / BeatWidth;
  localparam int StreamFlits   = 200;
  localparam int BurstFlits    = 20;
  localparam int TotalFlits    = 1 + StreamFlits + 2 * BurstFlits;
  localparam int TimeoutCycles = TotalFlits * NumSplits * ClkDiv * 2 + 200;

  logic                        clk;
  logic                        rst;
  logic                        flit_valid;
  logic                        flit_ready;
  logic                        flit_hdr;
  serial_link_pkg::flit_data_t flit_data;
  logic                        out_valid;
  logic                        out_hdr;
  serial_link_pkg::flit_data_t out_data;
  logic                        ddr_clk;
  logic [NumLanes-1:0]         ddr;
  logic                        test_end;
  logic                        run_done;
  int                          test_num;
  int                          offered;
  int                          received;
  int                          err_cnt;
  int                          cycle_cnt = 0;
  integer                      seed;

  tb_clk_gen clk_gen0 (
    .clk_o ( clk ),
    .rst_o ( rst )
  );

  // Lanes and forwarded clock looped straight back
  serial_link #(
    .NumLanes      ( NumLanes   ),
    .ClkDiv        ( ClkDiv     )
  ) dut0 (
    .clk_i         ( clk        ),
    .rst_i         ( rst        ),
    .flit_valid_i  ( flit_valid ),
    .flit_ready_o  ( flit_ready ),
    .flit_hdr_i    ( flit_hdr   ),
    .flit_data_i   ( flit_data  ),
    .flit_valid_o  ( out_valid  ),
    .flit_hdr_o    ( out_hdr    ),
    .flit_data_o   ( out_data   ),
    .ddr_rcv_clk_i ( ddr_clk    ),
    .ddr_rcv_clk_o ( ddr_clk    ),
    .ddr_i         ( ddr        ),
    .ddr_o         ( ddr        )
  );

  tb_checker #(
    .NumLanes     ( NumLanes   ),
    .ClkDiv       ( ClkDiv     ),
    .NumSplits    ( NumSplits  )
  ) check0 (
    .clk_i        ( clk        ),
    .rst_i        ( rst        ),
    .flit_valid_i ( flit_valid ),
    .flit_ready_i ( flit_ready ),
    .flit_hdr_i   ( flit_hdr   ),
    .flit_data_i  ( flit_data  ),
    .out_valid_i  ( out_valid  ),
    .out_hdr_i    ( out_hdr    ),
    .out_data_i   ( out_data   ),
    .line_clk_i   ( ddr_clk    ),
    .line_data_i  ( ddr        ),
    .test_num_i   ( test_num   ),
    .test_end_i   ( test_end   ),
    .run_done_i   ( run_done   ),
    .received_o   ( received   ),
    .err_cnt_o    ( err_cnt    )
  );

  function automatic int random_gap(input int max_gap);
    integer rnd;
    rnd = $random(seed);
    return (rnd & 32'h7fff_ffff) % (max_gap + 1);
  endfunction

  // Offer one flit after a gap and hold it until accepted
  task automatic send_flit(input int gap);
    integer rnd;
    if (gap > 0) begin
      flit_valid <= 1'b0;
      repeat (gap) @(posedge clk);
    end
    rnd = $random(seed);
    flit_valid <= 1'b1;
    flit_hdr   <= rnd[0];
    flit_data  <= $random(seed);
    @(posedge clk);
    while (!flit_ready) begin
      @(posedge clk);
    end
    offered++;
  endtask

  task automatic drain_link();
    flit_valid <= 1'b0;
    while (received != offered) begin
      @(posedge clk);
    end
    repeat (2 * ClkDiv) @(posedge clk);
  endtask

  task automatic end_test();
    test_end <= 1'b1;
    @(posedge clk);
    test_end <= 1'b0;
    test_num <= test_num + 1;
  endtask

  initial begin
    seed       = 32'h02238125;
    flit_valid = 1'b0;
    flit_hdr   = 1'b0;
    flit_data  = '0;
    test_end   = 1'b0;
    run_done   = 1'b0;
    test_num   = 1;
    offered    = 0;
    while (rst !== 1'b0) begin
      @(posedge clk);
    end

    // Reset values are checked on the first cycle out of reset
    repeat (4) @(posedge clk);
    end_test();

    send_flit(random_gap(7));
    drain_link();
    end_test();

    for (int i = 0; i < StreamFlits; i++) begin
      send_flit(random_gap(7));
    end
    drain_link();
    end_test();

    // Short gaps land inside the ready low window
    for (int i = 0; i < BurstFlits; i++) begin
      send_flit(random_gap(31));
    end
    drain_link();
    end_test();

    // Long gaps let the lines go idle
    for (int i = 0; i < BurstFlits; i++) begin
      send_flit(32 + random_gap(63));
    end
    drain_link();
    end_test();

    run_done <= 1'b1;
    @(posedge clk);
    run_done <= 1'b0;
    @(posedge clk);
    if (err_cnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TimeoutCycles) begin
      $display("Timeout: run did not finish within %0d cycles", TimeoutCycles);
      $display("Verification failed");
      $finish;
    end
  end

endmodule

// ==== vlog.f ====
logic/serial_link_pkg.sv
logic/serial_link_beat_if.sv
logic/serial_link_data_link.sv
logic/serial_link_physical.sv
logic/serial_link.sv
test/tb_clk_gen.sv
test/tb_checker.sv
test/tb_serial_link.sv

// ==== Bender.yml ====
package:
  name: serial_link

sources:
  # Link RTL in compile order
  - logic/serial_link_pkg.sv
  - logic/serial_link_beat_if.sv
  - logic/serial_link_data_link.sv
  - logic/serial_link_physical.sv
  - logic/serial_link.sv

  # Loopback testbench
  - target: test
    files:
      - test/tb_clk_gen.sv
      - test/tb_checker.sv
      - test/tb_serial_link.sv

Bender.yml
